//--- rtl/axi_pkg.sv
package axi_pkg;

  // Default widths match the top level parameters
  localparam int AXI_AW = 16;
  localparam int AXI_DW = 16;
  localparam int AXI_IW = 4;

  // Burst type codes where WRAP counts as INCR
  localparam logic [1:0] AXI_BURST_FIXED = 2'b00;
  localparam logic [1:0] AXI_BURST_INCR = 2'b01;

  typedef enum logic [1:0] {
    AXI_RESP_OKAY   = 2'b00,
    AXI_RESP_SLVERR = 2'b10
  } axi_resp_e;

  // AW and AR channel payload
  typedef struct packed {
    logic [AXI_IW-1:0] id;
    logic [AXI_AW-1:0] addr;
    logic [7:0]        len;
    logic [2:0]        size;
    logic [1:0]        burst;
  } axi_addr_t;

  // W channel payload
  typedef struct packed {
    logic [AXI_DW-1:0]   data;
    logic [AXI_DW/8-1:0] strb;
    logic                last;
  } axi_wbeat_t;

endpackage

//--- rtl/sram_pkg.sv
package sram_pkg;

  // Data width and word address width of the chip
  localparam int SRAM_DW = 16;
  localparam int SRAM_AW = 15;

  // One word access handed from the splitter to the controller
  typedef struct packed {
    logic                 wr;
    logic [SRAM_AW-1:0]   addr;
    logic [SRAM_DW-1:0]   data;
    logic [SRAM_DW/8-1:0] strb;
    logic                 last;
  } sram_req_t;

  typedef struct packed {
    logic [SRAM_DW-1:0] data;
    logic               last;
  } sram_rsp_t;

  // Chip control pins with active low strobes
  typedef struct packed {
    logic [SRAM_AW-1:0]   addr;
    logic                 ce_n;
    logic                 we_n;
    logic                 oe_n;
    logic [SRAM_DW/8-1:0] be_n;
  } sram_pins_t;

endpackage

//--- rtl/axi_burst_split.sv
module axi_burst_split #(
  parameter int AXI_ADDR_WIDTH = 16,
  parameter int AXI_DATA_WIDTH = 16,
  parameter int AXI_ID_WIDTH   = 4
) (
  input  logic                      clk,
  input  logic                      i_rst,

  input  axi_pkg::axi_addr_t        i_aw,
  input  logic                      i_aw_valid,
  output logic                      o_aw_ready,
  input  axi_pkg::axi_wbeat_t       i_w,
  input  logic                      i_w_valid,
  output logic                      o_w_ready,
  output logic [AXI_ID_WIDTH-1:0]   o_b_id,
  output axi_pkg::axi_resp_e        o_b_resp,
  output logic                      o_b_valid,
  input  logic                      i_b_ready,

  input  axi_pkg::axi_addr_t        i_ar,
  input  logic                      i_ar_valid,
  output logic                      o_ar_ready,
  output logic [AXI_ID_WIDTH-1:0]   o_r_id,
  output logic [AXI_DATA_WIDTH-1:0] o_r_data,
  output axi_pkg::axi_resp_e        o_r_resp,
  output logic                      o_r_last,
  output logic                      o_r_valid,
  input  logic                      i_r_ready,

  output sram_pkg::sram_req_t       o_req,
  output logic                      o_req_valid,
  input  logic                      i_req_ready,
  input  sram_pkg::sram_rsp_t       i_rsp,
  input  logic                      i_rsp_valid,
  output logic                      o_rsp_ready,
  input  logic                      i_wr_done
);
  import axi_pkg::*;
  import sram_pkg::*;

  localparam int LSB = $clog2(AXI_DATA_WIDTH / 8);
  localparam int WORD_AW = AXI_ADDR_WIDTH - LSB;

  // Held burst
  logic                    busy_q;
  logic                    is_wr_q;
  logic [AXI_ID_WIDTH-1:0] id_q;
  logic [WORD_AW-1:0]      addr_q;
  logic [1:0]              burst_q;
  logic                    iss_pend_q;
  logic [7:0]              iss_left_q;
  logic [7:0]              cmp_left_q;

  logic                    b_valid_q;
  logic                    err_q;
  logic                    prio_wr_q;

  // Output beat register holding the second beat in flight
  sram_req_t               req_q;
  logic                    req_valid_q;

  logic                    idle;
  logic                    aw_go;
  logic                    ar_go;
  logic                    load_ok;
  logic                    beat_go;
  logic                    w_go;
  logic                    rd_done;
  axi_addr_t               addr_sel;

  // Read wins a tie first, then the two take turns
  assign idle       = !busy_q && !b_valid_q;
  assign o_ar_ready = idle && (!i_aw_valid || !prio_wr_q);
  assign o_aw_ready = idle && (!i_ar_valid || prio_wr_q);
  assign ar_go      = o_ar_ready && i_ar_valid;
  assign aw_go      = o_aw_ready && i_aw_valid;
  assign addr_sel   = aw_go ? i_aw : i_ar;

  assign load_ok   = !req_valid_q || i_req_ready;
  assign o_w_ready = busy_q && is_wr_q && iss_pend_q && load_ok;
  assign w_go      = o_w_ready && i_w_valid;
  assign beat_go   = busy_q && iss_pend_q && load_ok && (!is_wr_q || i_w_valid);
  assign rd_done   = i_rsp_valid && i_r_ready && i_rsp.last;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      busy_q      <= 1'b0;
      iss_pend_q  <= 1'b0;
      req_valid_q <= 1'b0;
      b_valid_q   <= 1'b0;
      err_q       <= 1'b0;
      prio_wr_q   <= 1'b0;
    end else begin
      if (aw_go || ar_go) begin
        busy_q     <= 1'b1;
        iss_pend_q <= 1'b1;
        err_q      <= 1'b0;
        prio_wr_q  <= ar_go;
      end
      if (beat_go && iss_left_q == 8'd0) begin
        iss_pend_q <= 1'b0;
      end

      if (beat_go) begin
        req_valid_q <= 1'b1;
      end else if (i_req_ready) begin
        req_valid_q <= 1'b0;
      end

      // wlast must line up with the beat count from AW
      if (w_go && (i_w.last != (iss_left_q == 8'd0))) begin
        err_q <= 1'b1;
      end

      if (i_wr_done && cmp_left_q == 8'd0) begin
        busy_q    <= 1'b0;
        b_valid_q <= 1'b1;
      end
      if (rd_done) begin
        busy_q <= 1'b0;
      end
      if (b_valid_q && i_b_ready) begin
        b_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_go || ar_go) begin
      is_wr_q    <= aw_go;
      id_q       <= addr_sel.id;
      addr_q     <= addr_sel.addr[AXI_ADDR_WIDTH-1:LSB];
      iss_left_q <= addr_sel.len;
      cmp_left_q <= addr_sel.len;
      burst_q    <= (addr_sel.burst == AXI_BURST_FIXED) ? AXI_BURST_FIXED : AXI_BURST_INCR;
    end

    if (beat_go) begin
      req_q.wr   <= is_wr_q;
      req_q.addr <= addr_q;
      req_q.data <= is_wr_q ? i_w.data : '0;
      req_q.strb <= is_wr_q ? i_w.strb : '1;
      req_q.last <= (iss_left_q == 8'd0);
      iss_left_q <= iss_left_q - 8'd1;
      if (burst_q != AXI_BURST_FIXED) begin
        addr_q <= addr_q + 1'b1;
      end
    end

    if (i_wr_done) begin
      cmp_left_q <= cmp_left_q - 8'd1;
    end
  end

  assign o_req       = req_q;
  assign o_req_valid = req_valid_q;

  assign o_b_valid = b_valid_q;
  assign o_b_id    = id_q;
  assign o_b_resp  = err_q ? AXI_RESP_SLVERR : AXI_RESP_OKAY;

  // Read beats pass straight through and rready stalls the controller
  assign o_r_valid   = i_rsp_valid;
  assign o_r_data    = i_rsp.data;
  assign o_r_last    = i_rsp.last;
  assign o_r_id      = id_q;
  assign o_r_resp    = AXI_RESP_OKAY;
  assign o_rsp_ready = i_r_ready;

  a_req_hold: assert property (@(posedge clk) disable iff (i_rst)
    o_req_valid && !i_req_ready |=> o_req_valid && $stable(o_req));

  a_wlast_match: assert property (@(posedge clk) disable iff (i_rst)
    i_w_valid && o_w_ready |-> i_w.last == (iss_left_q == 8'd0));

endmodule

//--- rtl/sram_ctrl.sv
module sram_ctrl #(
  parameter int AXI_ADDR_WIDTH   = 16,
  parameter int AXI_DATA_WIDTH   = 16,
  parameter int SRAM_WAIT_CYCLES = 1
) (
  input  logic                      clk,
  input  logic                      i_rst,

  input  sram_pkg::sram_req_t       i_req,
  input  logic                      i_req_valid,
  output logic                      o_req_ready,
  output sram_pkg::sram_rsp_t       o_rsp,
  output logic                      o_rsp_valid,
  input  logic                      i_rsp_ready,
  output logic                      o_wr_done,

  output sram_pkg::sram_pins_t      o_pins,
  output logic [AXI_DATA_WIDTH-1:0] o_dq_out,
  output logic                      o_dq_oe,
  input  logic [AXI_DATA_WIDTH-1:0] i_dq
);
  import sram_pkg::*;

  localparam int CNT_W = (SRAM_WAIT_CYCLES > 0) ? $clog2(SRAM_WAIT_CYCLES + 1) : 1;
  localparam int WORD_AW = AXI_ADDR_WIDTH - $clog2(AXI_DATA_WIDTH / 8);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ACCESS,
    ST_RECOVER,
    ST_HOLD
  } state_e;

  // Package structs are fixed at the default bus
  if (WORD_AW != SRAM_AW || AXI_DATA_WIDTH != SRAM_DW) begin : g_width_check
    $error("sram_pkg widths do not match the bus parameters");
  end

  state_e             state_q;
  logic [CNT_W-1:0]   cnt_q;
  logic               last_wait;
  sram_req_t          req_q;
  logic [SRAM_DW-1:0] rsp_data_q;

  // Strobes are registered so the chip never sees decode glitches
  logic               ce_n_q;
  logic               we_n_q;
  logic               oe_n_q;
  logic               dq_oe_q;
  logic               wr_done_q;

  assign last_wait   = (cnt_q == CNT_W'(SRAM_WAIT_CYCLES));
  assign o_req_ready = (state_q == ST_IDLE);

  always_ff @(posedge clk) begin
    if (i_rst) begin
      state_q   <= ST_IDLE;
      cnt_q     <= '0;
      ce_n_q    <= 1'b1;
      we_n_q    <= 1'b1;
      oe_n_q    <= 1'b1;
      dq_oe_q   <= 1'b0;
      wr_done_q <= 1'b0;
    end else begin
      wr_done_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (i_req_valid) begin
            state_q <= ST_ACCESS;
            cnt_q   <= '0;
            ce_n_q  <= 1'b0;
            we_n_q  <= !i_req.wr;
            oe_n_q  <= i_req.wr;
            dq_oe_q <= i_req.wr;
          end
        end
        ST_ACCESS: begin
          if (last_wait) begin
            ce_n_q  <= 1'b1;
            we_n_q  <= 1'b1;
            oe_n_q  <= 1'b1;
            state_q <= req_q.wr ? ST_RECOVER : ST_HOLD;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        // Data still driven while we_n rises
        ST_RECOVER: begin
          dq_oe_q   <= 1'b0;
          wr_done_q <= 1'b1;
          state_q   <= ST_IDLE;
        end
        ST_HOLD: begin
          if (i_rsp_ready) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (o_req_ready && i_req_valid) begin
      req_q <= i_req;
    end
    if (state_q == ST_ACCESS && last_wait && !req_q.wr) begin
      rsp_data_q <= i_dq;
    end
  end

  assign o_pins.addr = req_q.addr;
  assign o_pins.ce_n = ce_n_q;
  assign o_pins.we_n = we_n_q;
  assign o_pins.oe_n = oe_n_q;
  assign o_pins.be_n = ~req_q.strb;

  assign o_dq_out = req_q.data;
  assign o_dq_oe  = dq_oe_q;

  assign o_rsp.data  = rsp_data_q;
  assign o_rsp.last  = req_q.last;
  assign o_rsp_valid = (state_q == ST_HOLD);
  assign o_wr_done   = wr_done_q;

  a_we_oe_excl: assert property (@(posedge clk) disable iff (i_rst)
    we_n_q || oe_n_q);

  // Bus contention guard against the chip output
  a_dq_drive: assert property (@(posedge clk) disable iff (i_rst)
    dq_oe_q |-> (!we_n_q || state_q == ST_RECOVER));

endmodule

//--- rtl/axi_sram.sv
module axi_sram #(
  parameter int AXI_ADDR_WIDTH   = 16,
  parameter int AXI_DATA_WIDTH   = 16,
  parameter int AXI_ID_WIDTH     = 4,
  parameter int SRAM_WAIT_CYCLES = 1
) (
  input  logic                      clk,
  input  logic                      i_rst,

  input  axi_pkg::axi_addr_t        i_aw,
  input  logic                      i_aw_valid,
  output logic                      o_aw_ready,
  input  axi_pkg::axi_wbeat_t       i_w,
  input  logic                      i_w_valid,
  output logic                      o_w_ready,
  output logic [AXI_ID_WIDTH-1:0]   o_b_id,
  output axi_pkg::axi_resp_e        o_b_resp,
  output logic                      o_b_valid,
  input  logic                      i_b_ready,

  input  axi_pkg::axi_addr_t        i_ar,
  input  logic                      i_ar_valid,
  output logic                      o_ar_ready,
  output logic [AXI_ID_WIDTH-1:0]   o_r_id,
  output logic [AXI_DATA_WIDTH-1:0] o_r_data,
  output axi_pkg::axi_resp_e        o_r_resp,
  output logic                      o_r_last,
  output logic                      o_r_valid,
  input  logic                      i_r_ready,

  output logic [AXI_ADDR_WIDTH-$clog2(AXI_DATA_WIDTH/8)-1:0] o_sram_addr,
  output logic                      o_sram_ce_n,
  output logic                      o_sram_we_n,
  output logic                      o_sram_oe_n,
  output logic [AXI_DATA_WIDTH/8-1:0] o_sram_be_n,
  inout  wire  [AXI_DATA_WIDTH-1:0] io_sram_data
);
  import sram_pkg::*;

  sram_req_t                 req;
  logic                      req_valid;
  logic                      req_ready;
  sram_rsp_t                 rsp;
  logic                      rsp_valid;
  logic                      rsp_ready;
  logic                      wr_done;
  sram_pins_t                pins;
  logic [AXI_DATA_WIDTH-1:0] dq_out;
  logic                      dq_oe;

  axi_burst_split #(
    .AXI_ADDR_WIDTH(AXI_ADDR_WIDTH),
    .AXI_DATA_WIDTH(AXI_DATA_WIDTH),
    .AXI_ID_WIDTH  (AXI_ID_WIDTH)
  ) u_split (
    .clk        (clk),
    .i_rst      (i_rst),
    .i_aw       (i_aw),
    .i_aw_valid (i_aw_valid),
    .o_aw_ready (o_aw_ready),
    .i_w        (i_w),
    .i_w_valid  (i_w_valid),
    .o_w_ready  (o_w_ready),
    .o_b_id     (o_b_id),
    .o_b_resp   (o_b_resp),
    .o_b_valid  (o_b_valid),
    .i_b_ready  (i_b_ready),
    .i_ar       (i_ar),
    .i_ar_valid (i_ar_valid),
    .o_ar_ready (o_ar_ready),
    .o_r_id     (o_r_id),
    .o_r_data   (o_r_data),
    .o_r_resp   (o_r_resp),
    .o_r_last   (o_r_last),
    .o_r_valid  (o_r_valid),
    .i_r_ready  (i_r_ready),
    .o_req      (req),
    .o_req_valid(req_valid),
    .i_req_ready(req_ready),
    .i_rsp      (rsp),
    .i_rsp_valid(rsp_valid),
    .o_rsp_ready(rsp_ready),
    .i_wr_done  (wr_done)
  );

  sram_ctrl #(
    .AXI_ADDR_WIDTH  (AXI_ADDR_WIDTH),
    .AXI_DATA_WIDTH  (AXI_DATA_WIDTH),
    .SRAM_WAIT_CYCLES(SRAM_WAIT_CYCLES)
  ) u_ctrl (
    .clk        (clk),
    .i_rst      (i_rst),
    .i_req      (req),
    .i_req_valid(req_valid),
    .o_req_ready(req_ready),
    .o_rsp      (rsp),
    .o_rsp_valid(rsp_valid),
    .i_rsp_ready(rsp_ready),
    .o_wr_done  (wr_done),
    .o_pins     (pins),
    .o_dq_out   (dq_out),
    .o_dq_oe    (dq_oe),
    .i_dq       (io_sram_data)
  );

  assign o_sram_addr = pins.addr;
  assign o_sram_ce_n = pins.ce_n;
  assign o_sram_we_n = pins.we_n;
  assign o_sram_oe_n = pins.oe_n;
  assign o_sram_be_n = pins.be_n;

  // Only driver of the shared data bus
  assign io_sram_data = dq_oe ? dq_out : 'z;

endmodule

//--- sim/sram_model.sv
module sram_model #(
  parameter int ADDR_W = 15,
  parameter int DATA_W = 16
) (
  input  logic [ADDR_W-1:0]   i_addr,
  input  logic                i_ce_n,
  input  logic                i_we_n,
  input  logic                i_oe_n,
  input  logic [DATA_W/8-1:0] i_be_n,
  inout  wire  [DATA_W-1:0]   io_data
);

  logic [DATA_W-1:0] mem [0:2**ADDR_W-1];
  logic [DATA_W-1:0] rd_word;
  logic              wr_active;

  // Unwritten words read back as their address xor 5a5a
  initial begin
    for (int i = 0; i < 2**ADDR_W; i++) begin
      mem[i] = DATA_W'(i) ^ {(DATA_W/8){8'h5a}};
    end
  end

  assign wr_active = !i_ce_n && !i_we_n;

  // Data is latched as the write strobe ends
  always @(negedge wr_active) begin
    if (!$isunknown(i_addr)) begin
      for (int b = 0; b < DATA_W/8; b++) begin
        if (!i_be_n[b]) begin
          mem[i_addr][8*b +: 8] = io_data[8*b +: 8];
        end
      end
    end
  end

  assign rd_word = mem[i_addr];

  for (genvar b = 0; b < DATA_W/8; b++) begin : g_byte
    assign io_data[8*b +: 8] = (!i_ce_n && !i_oe_n && i_we_n && !i_be_n[b]) ?
                               rd_word[8*b +: 8] : 8'bz;
  end

endmodule

//--- sim/axi_sram_tb.sv
module axi_sram_tb;
  import axi_pkg::*;

  localparam int ADDR_W      = 16;
  localparam int DATA_W      = 16;
  localparam int ID_W        = 4;
  localparam int STRB_W      = DATA_W / 8;
  localparam int WORD_AW     = ADDR_W - $clog2(STRB_W);
  localparam int WAIT_CYCLES = 1;
  localparam int COLS        = 16;
  localparam int MAX_LINES   = 32;

  logic                clk;
  logic                i_rst;
  axi_addr_t           i_aw;
  logic                i_aw_valid;
  logic                o_aw_ready;
  axi_wbeat_t          i_w;
  logic                i_w_valid;
  logic                o_w_ready;
  logic [ID_W-1:0]     o_b_id;
  axi_resp_e           o_b_resp;
  logic                o_b_valid;
  logic                i_b_ready;
  axi_addr_t           i_ar;
  logic                i_ar_valid;
  logic                o_ar_ready;
  logic [ID_W-1:0]     o_r_id;
  logic [DATA_W-1:0]   o_r_data;
  axi_resp_e           o_r_resp;
  logic                o_r_last;
  logic                o_r_valid;
  logic                i_r_ready;
  logic [WORD_AW-1:0]  sram_addr;
  logic                sram_ce_n;
  logic                sram_we_n;
  logic                sram_oe_n;
  logic [STRB_W-1:0]   sram_be_n;
  wire  [DATA_W-1:0]   sram_data;

  logic [15:0]         trace_mem [0:MAX_LINES*COLS-1];
  logic [31:0]         stall_rng;
  logic [31:0]         delay_rng;
  logic                stall_en;
  int                  errors;
  int                  test_errors;
  int                  checks;
  int                  tests_done;
  int                  cycles;
  int                  cycle_limit;

  axi_sram #(
    .AXI_ADDR_WIDTH  (ADDR_W),
    .AXI_DATA_WIDTH  (DATA_W),
    .AXI_ID_WIDTH    (ID_W),
    .SRAM_WAIT_CYCLES(WAIT_CYCLES)
  ) dut (
    .clk(clk), .i_rst(i_rst),
    .i_aw(i_aw), .i_aw_valid(i_aw_valid), .o_aw_ready(o_aw_ready),
    .i_w(i_w), .i_w_valid(i_w_valid), .o_w_ready(o_w_ready),
    .o_b_id(o_b_id), .o_b_resp(o_b_resp), .o_b_valid(o_b_valid), .i_b_ready(i_b_ready),
    .i_ar(i_ar), .i_ar_valid(i_ar_valid), .o_ar_ready(o_ar_ready),
    .o_r_id(o_r_id), .o_r_data(o_r_data), .o_r_resp(o_r_resp), .o_r_last(o_r_last),
    .o_r_valid(o_r_valid), .i_r_ready(i_r_ready),
    .o_sram_addr(sram_addr), .o_sram_ce_n(sram_ce_n), .o_sram_we_n(sram_we_n),
    .o_sram_oe_n(sram_oe_n), .o_sram_be_n(sram_be_n), .io_sram_data(sram_data)
  );

  sram_model #(
    .ADDR_W(WORD_AW),
    .DATA_W(DATA_W)
  ) u_sram (
    .i_addr(sram_addr), .i_ce_n(sram_ce_n), .i_we_n(sram_we_n),
    .i_oe_n(sram_oe_n), .i_be_n(sram_be_n), .io_data(sram_data)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [15:0] field(input int line, input int col);
    return trace_mem[line*COLS + col];
  endfunction

  function automatic int next_delay();
    delay_rng = xorshift(delay_rng);
    return int'(delay_rng[1:0]);
  endfunction

  function automatic axi_wbeat_t wbeat(input int line, input int k, input int beats);
    axi_wbeat_t b;
    b.data = field(line, 8 + k);
    b.strb = STRB_W'(field(line, 7));
    b.last = (k == beats - 1);
    return b;
  endfunction

  function automatic axi_addr_t addr_beat(input int line);
    axi_addr_t a;
    a.id    = ID_W'(field(line, 3));
    a.addr  = field(line, 4);
    a.len   = 8'(field(line, 5));
    a.size  = 3'($clog2(STRB_W));
    a.burst = 2'(field(line, 6));
    return a;
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    checks++;
    if (actual !== expected) begin
      $display("Fail at %0t: %s, got %h, expected %h", $time, what, actual, expected);
      errors++;
      test_errors++;
    end
  endtask

  task automatic report_test(input int num);
    $display("Test %0d finished with %0d errors", num, test_errors);
    tests_done++;
    test_errors = 0;
  endtask

  task automatic run_write(input int line, input bit may_delay, output time done_at);
    axi_addr_t aw;
    int        beats;
    int        sent;
    bit        aw_done;
    bit        aw_xfer;
    bit        w_xfer;
    aw      = addr_beat(line);
    beats   = int'(aw.len) + 1;
    sent    = 0;
    aw_done = 1'b0;
    if (may_delay && field(line, 2) != 16'h0) begin
      repeat (next_delay()) @(posedge clk);
    end
    @(posedge clk);
    i_aw       <= aw;
    i_aw_valid <= 1'b1;
    i_w        <= wbeat(line, 0, beats);
    i_w_valid  <= 1'b1;
    while (!aw_done || sent < beats) begin
      @(negedge clk);
      aw_xfer = i_aw_valid && o_aw_ready;
      w_xfer  = i_w_valid && o_w_ready;
      @(posedge clk);
      if (aw_xfer) begin
        aw_done = 1'b1;
        i_aw_valid <= 1'b0;
      end
      if (w_xfer) begin
        sent++;
        if (sent < beats) begin
          i_w <= wbeat(line, sent, beats);
        end else begin
          i_w_valid <= 1'b0;
        end
      end
    end
    do @(negedge clk); while (!(o_b_valid && i_b_ready));
    check_value(o_b_id, aw.id, "write response ID");
    check_value(o_b_resp, AXI_RESP_OKAY, "write response code");
    done_at = $time;
    @(posedge clk);
  endtask

  task automatic run_read(input int line, input bit may_delay, output time done_at);
    axi_addr_t ar;
    int        beats;
    int        got;
    ar    = addr_beat(line);
    beats = int'(ar.len) + 1;
    got   = 0;
    if (may_delay && field(line, 2) != 16'h0) begin
      repeat (next_delay()) @(posedge clk);
    end
    @(posedge clk);
    i_ar       <= ar;
    i_ar_valid <= 1'b1;
    do @(negedge clk); while (!o_ar_ready);
    @(posedge clk);
    i_ar_valid <= 1'b0;
    while (got < beats) begin
      @(negedge clk);
      if (o_r_valid && i_r_ready) begin
        check_value(o_r_data, field(line, 8 + got), "read data");
        check_value(o_r_id, ar.id, "read ID");
        check_value(o_r_resp, AXI_RESP_OKAY, "read response code");
        check_value(o_r_last, (got == beats - 1), "read last flag");
        got++;
      end
    end
    done_at = $time;
    @(posedge clk);
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Random back-pressure on R and B while a line asks for stalls
  always @(posedge clk) begin
    if (stall_en) begin
      i_r_ready <= (stall_rng[1:0] != 2'b00);
      i_b_ready <= (stall_rng[3:2] != 2'b00);
    end else begin
      i_r_ready <= 1'b1;
      i_b_ready <= 1'b1;
    end
    stall_rng <= xorshift(stall_rng);
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin
    int          line;
    int          nlines;
    int          total_beats;
    logic [15:0] cur_test;
    time         wr_at;
    time         rd_at;
    i_rst       = 1'b1;
    i_aw        = '0;
    i_aw_valid  = 1'b0;
    i_w         = '0;
    i_w_valid   = 1'b0;
    i_b_ready   = 1'b0;
    i_ar        = '0;
    i_ar_valid  = 1'b0;
    i_r_ready   = 1'b0;
    stall_en    = 1'b0;
    stall_rng   = xorshift(32'd46);
    delay_rng   = 32'd46;
    errors      = 0;
    test_errors = 0;
    checks      = 0;
    tests_done  = 0;
    cycles      = 0;
    cycle_limit = 0;
    cur_test    = '0;

    $readmemh("sim/axi_sram_trace.txt", trace_mem);
    nlines      = 0;
    total_beats = 0;
    while (nlines < MAX_LINES && field(nlines, 1) != 16'hf) begin
      total_beats += int'(field(nlines, 5)) + 1;
      nlines++;
    end
    if (nlines == 0) begin
      $display("The trace file holds no bursts");
      errors++;
    end
    // Beat time plus room for stalls, handshakes and reset
    cycle_limit = total_beats * (WAIT_CYCLES + 3) + total_beats * 8 + nlines * 16 + 64;

    repeat (3) @(posedge clk);
    i_rst <= 1'b0;

    line = 0;
    if (nlines > 0) begin
      cur_test = field(0, 0);
    end
    while (line < nlines) begin
      if (field(line, 0) != cur_test) begin
        report_test(cur_test);
        cur_test = field(line, 0);
      end
      stall_en <= (field(line, 2) != 16'h0);
      if (field(line, 1) == 16'h2) begin
        fork
          run_write(line, 1'b0, wr_at);
          run_read(line + 1, 1'b0, rd_at);
        join
        check_value(rd_at < wr_at, 1, "read served before write");
        line = line + 2;
      end else if (field(line, 1) == 16'h1) begin
        run_read(line, 1'b1, rd_at);
        line++;
      end else begin
        run_write(line, 1'b1, wr_at);
        line++;
      end
    end
    if (nlines > 0) begin
      report_test(cur_test);
    end

    $display("%0d tests, %0d checks, %0d errors", tests_done, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- sim/axi_sram_trace.txt
// test op stall id addr len burst strb data0 .. data7, all hex, len is beats minus one
// op 0 write, 1 read with expected data, 2 write raised together with the next read, f end
1 0 0 1 0010 0 1 3 1234 0000 0000 0000 0000 0000 0000 0000
1 1 0 2 0010 0 1 3 1234 0000 0000 0000 0000 0000 0000 0000
2 0 0 3 0100 7 1 3 a001 b102 c203 d304 e405 f506 0607 1708
2 1 0 4 0100 7 1 3 a001 b102 c203 d304 e405 f506 0607 1708
3 0 0 5 0200 0 1 3 5566 0000 0000 0000 0000 0000 0000 0000
3 0 0 6 0200 0 1 1 99ab 0000 0000 0000 0000 0000 0000 0000
3 1 0 7 0200 0 1 3 55ab 0000 0000 0000 0000 0000 0000 0000
3 0 0 8 0202 0 1 3 7788 0000 0000 0000 0000 0000 0000 0000
3 0 0 9 0202 0 1 2 cdee 0000 0000 0000 0000 0000 0000 0000
3 1 0 a 0202 0 1 3 cd88 0000 0000 0000 0000 0000 0000 0000
4 0 0 b 0300 3 0 3 1111 2222 3333 4444 0000 0000 0000 0000
4 1 0 c 0300 1 1 3 4444 5bdb 0000 0000 0000 0000 0000 0000
5 0 1 d 0400 7 1 3 c0de 1357 2468 9bdf 3c3c 5a5a 8001 fffe
5 1 1 e 0400 7 1 3 c0de 1357 2468 9bdf 3c3c 5a5a 8001 fffe
5 0 1 1 0410 3 1 3 4321 8765 cba9 0fed 0000 0000 0000 0000
5 1 1 2 0410 3 1 3 4321 8765 cba9 0fed 0000 0000 0000 0000
5 1 1 3 0010 0 1 3 1234 0000 0000 0000 0000 0000 0000 0000
6 0 0 4 0500 0 1 3 6666 0000 0000 0000 0000 0000 0000 0000
6 2 0 5 0500 0 1 3 7777 0000 0000 0000 0000 0000 0000 0000
6 1 0 6 0500 0 1 3 6666 0000 0000 0000 0000 0000 0000 0000
6 1 0 7 0500 0 1 3 7777 0000 0000 0000 0000 0000 0000 0000
f f 0 0 0000 0 0 0 0000 0000 0000 0000 0000 0000 0000 0000

//--- flist.f
rtl/axi_pkg.sv
rtl/sram_pkg.sv
rtl/axi_burst_split.sv
rtl/sram_ctrl.sv
rtl/axi_sram.sv
sim/sram_model.sv
sim/axi_sram_tb.sv
